//--- all.f
mmu_pkg.sv
tlb_ptw_if.sv
tlb.sv
ptw.sv
mmu_top.sv
mmu_checker.sv
mmu_asserts.sv
tb_mmu.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide the result from the simulation log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_mmu \
    -o sim_mmu > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/sim_mmu > sim.log 2>&1
cat sim.log
grep -qx "All checks passed" sim.log && echo "RESULT: PASS" || { echo "RESULT: FAIL"; exit 1; }

//--- tb_mmu.sv
// MMU testbench with clock, reset, LCG stimulus, page table memory model and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_mmu
    import mmu_pkg::*;
();

    localparam int unsigned NumReq        = 25;
    localparam int unsigned TimeoutCycles = 8 + 40 * NumReq;
    localparam logic [PpnWidth-1:0] PpnPattern = 44'h5a5_a5a5_a5a5;
    localparam logic [PpnWidth-1:0] PtbrValue  = 44'h000_0012_3400;

    logic clk_i, rst_n_i, vm_enable_i, flush_i;
    logic ifetch_req_i, ifetch_ready_o, ifetch_resp_valid_o, ifetch_xcpt_o;
    logic dmem_req_i, dmem_store_i, dmem_ready_o, dmem_resp_valid_o, dmem_xcpt_o;
    logic [VpnWidth-1:0]   ifetch_vpn_i, dmem_vpn_i;
    logic [PpnWidth-1:0]   ptbr_i, ifetch_ppn_o, dmem_ppn_o;
    logic                  mem_req_valid_o, mem_req_ready_i, mem_resp_valid_i;
    logic [PAddrWidth-1:0] mem_req_addr_o;
    logic [PteWidth-1:0]   mem_resp_data_i;

    int                    cycles, tb_errors, chk_errors, chk_count, mem_reads, test_errs;
    logic [31:0]           stim_seed, mem_seed;
    logic [PAddrWidth-1:0] addr_log[$];
    logic [PAddrWidth-1:0] mem_addr;
    logic [1:0]            mem_delay;
    logic                  mem_pending;

    mmu_top #(.TlbEntries(8)) UUT (.*);

    mmu_checker #(.PpnPattern(PpnPattern)) checker_inst (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .vm_enable_i(vm_enable_i),
        .ifetch_req_i(ifetch_req_i), .ifetch_vpn_i(ifetch_vpn_i),
        .ifetch_ready_i(ifetch_ready_o), .ifetch_resp_valid_i(ifetch_resp_valid_o),
        .ifetch_xcpt_i(ifetch_xcpt_o), .ifetch_ppn_i(ifetch_ppn_o),
        .dmem_req_i(dmem_req_i), .dmem_store_i(dmem_store_i), .dmem_vpn_i(dmem_vpn_i),
        .dmem_ready_i(dmem_ready_o), .dmem_resp_valid_i(dmem_resp_valid_o),
        .dmem_xcpt_i(dmem_xcpt_o), .dmem_ppn_i(dmem_ppn_o),
        .err_cnt_o(chk_errors), .chk_cnt_o(chk_count)
    );

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [PAddrWidth-1:0] pte_addr(input logic [VpnWidth-1:0] vpn);
        return {PtbrValue, 12'h000} + {26'b0, vpn, 3'b000};
    endfunction

    // Page table contents, all fields derived from the VPN
    function automatic logic [PteWidth-1:0] pte_of(input logic [PAddrWidth-1:0] addr);
        logic [VpnWidth-1:0] vpn;
        logic [PteWidth-1:0] pte;
        vpn         = VpnWidth'((addr - {PtbrValue, 12'h000}) >> 3);
        pte         = '0;
        pte[53:10]  = PpnWidth'(vpn) ^ PpnPattern;
        pte[3]      = vpn[6];
        pte[2]      = vpn[5];
        pte[1]      = vpn[4];
        pte[0]      = (vpn[3:0] != 4'hf);
        return pte;
    endfunction

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles == TimeoutCycles) begin
            $display("Run timed out after %0d cycles without finishing the tests", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Memory model with random back-pressure and latency
    // ------------------------------------------------------------------------
    always @(posedge clk_i) begin
        if (rst_n_i) begin
            mem_seed = lcg(mem_seed);
            mem_req_ready_i  <= (mem_seed[21:20] != 2'b00);
            mem_resp_valid_i <= 1'b0;
            if (mem_req_valid_o && mem_req_ready_i) begin
                mem_pending = 1'b1;
                mem_addr    = mem_req_addr_o;
                mem_delay   = mem_seed[25:24];
                mem_reads++;
                addr_log.push_back(mem_req_addr_o);
            end else if (mem_pending) begin
                if (mem_delay == 2'd0) begin
                    mem_resp_valid_i <= 1'b1;
                    mem_resp_data_i  <= pte_of(mem_addr);
                    mem_pending = 1'b0;
                end else begin
                    mem_delay--;
                end
            end
        end
    end

    task automatic translate(input bit dside, input logic [VpnWidth-1:0] vpn, input bit store,
                             output int lat, output logic xcpt);
        lat = 0;
        @(posedge clk_i);
        if (dside) begin
            dmem_req_i   <= 1'b1;
            dmem_vpn_i   <= vpn;
            dmem_store_i <= store;
        end else begin
            ifetch_req_i <= 1'b1;
            ifetch_vpn_i <= vpn;
        end
        @(posedge clk_i);
        if (dside) dmem_req_i <= 1'b0;
        else ifetch_req_i <= 1'b0;
        do begin
            @(negedge clk_i);
            lat++;
        end while (!(dside ? dmem_resp_valid_o : ifetch_resp_valid_o));
        xcpt = dside ? dmem_xcpt_o : ifetch_xcpt_o;
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("Wrong %s: expected %0d, got %0d", what, exp, got);
            tb_errors++;
        end
    endtask

    task automatic check_hex(input string sig, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail %s expected 0x%h got 0x%h", sig, exp, got);
            tb_errors++;
        end
    endtask

    // Last response of the test is compared by the checker on the next rising edge
    task automatic end_test(input string name);
        int now;
        @(posedge clk_i);
        @(negedge clk_i);
        now = tb_errors + chk_errors;
        if (now == test_errs) $display("Test %s: ok", name);
        else $display("Test %s: %0d errors", name, now - test_errs);
        test_errs = now;
    endtask

    initial begin
        logic [VpnWidth-1:0] vpns[6];
        logic [VpnWidth-1:0] vpn, dvpn;
        int                  lat, dlat, r0;
        logic                xcpt, dxcpt;
        {vm_enable_i, flush_i, ifetch_req_i, dmem_req_i, dmem_store_i} = '0;
        {ifetch_vpn_i, dmem_vpn_i, mem_resp_data_i} = '0;
        {mem_req_ready_i, mem_resp_valid_i, mem_pending, mem_delay} = '0;
        ptbr_i = PtbrValue;
        mem_addr = '0;
        {cycles, tb_errors, mem_reads, test_errs} = '0;
        stim_seed = 32'd98;
        mem_seed  = 32'd98 ^ 32'h1234;
        rst_n_i   = 1'b0;
        repeat (8) @(posedge clk_i);
        rst_n_i <= 1'b1;

        for (int i = 0; i < 6; i++) begin
            stim_seed = lcg(stim_seed);
            translate(i % 2 == 1, stim_seed[31:5], i == 3, lat, xcpt);
            check_count("passthrough latency", lat, 1);
        end
        check_count("memory reads with translation off", mem_reads, 0);
        end_test("1 passthrough");

        @(posedge clk_i);
        vm_enable_i <= 1'b1;
        for (int i = 0; i < 6; i++) begin
            stim_seed = lcg(stim_seed);
            vpns[i] = {stim_seed[31:8], 3'(i)};
            r0 = mem_reads;
            translate(i % 2 == 1, vpns[i], i == 3, lat, xcpt);
            check_count("memory reads on a first access", mem_reads - r0, 1);
            check_hex("mem_req_addr_o", 64'(addr_log[$]), 64'(pte_addr(vpns[i])));
        end
        end_test("2 first access walks");

        r0 = mem_reads;
        for (int i = 0; i < 6; i++) begin
            translate(i % 2 == 1, vpns[i], i == 3, lat, xcpt);
            check_count("hit latency", lat, 1);
        end
        check_count("memory reads on hits", mem_reads - r0, 0);
        end_test("3 repeated access hits");

        // Store to W clear, fetch from X clear, load from V clear
        translate(1'b1, {20'habcde, 7'h51}, 1'b1, lat, xcpt);
        check_hex("dmem_xcpt_o", 64'(xcpt), 64'h1);
        translate(1'b0, {20'h0badc, 7'h31}, 1'b0, lat, xcpt);
        check_hex("ifetch_xcpt_o", 64'(xcpt), 64'h1);
        translate(1'b1, {20'h7e7e7, 7'h3f}, 1'b0, lat, xcpt);
        check_hex("dmem_xcpt_o", 64'(xcpt), 64'h1);
        end_test("4 permission faults");

        vpn  = {20'h2468a, 7'h56};
        dvpn = {20'h13579, 7'h12};
        r0   = mem_reads;
        fork
            translate(1'b1, dvpn, 1'b0, dlat, dxcpt);
            translate(1'b0, vpn, 1'b0, lat, xcpt);
        join
        check_count("memory reads for two misses", mem_reads - r0, 2);
        check_hex("mem_req_addr_o", 64'(addr_log[r0]), 64'(pte_addr(dvpn)));
        end_test("5 simultaneous misses");

        r0 = mem_reads;
        translate(1'b0, vpns[0], 1'b0, lat, xcpt);
        check_count("memory reads before flush", mem_reads - r0, 0);
        @(posedge clk_i);
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
        translate(1'b0, vpns[0], 1'b0, lat, xcpt);
        check_count("memory reads after flush", mem_reads - r0, 1);
        end_test("6 flush");

        @(posedge clk_i);
        check_count("responses compared", chk_count, NumReq);
        $display("Responses compared %0d, testbench errors %0d, checker errors %0d",
                 chk_count, tb_errors, chk_errors);
        if (tb_errors == 0 && chk_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mmu_asserts.sv
// Protocol assertions for the MMU memory port, requester sides and refill buses
`timescale 1ns/1ps
`default_nettype none

module mmu_asserts
    import mmu_pkg::*;
(
    input logic                  clk_i,
    input logic                  rst_n_i,
    input logic                  mem_req_valid_i,
    input logic [PAddrWidth-1:0] mem_req_addr_i,
    input logic                  mem_req_ready_i,
    input logic                  ifetch_ready_i,
    input logic                  ifetch_resp_valid_i,
    input logic                  dmem_ready_i,
    input logic                  dmem_resp_valid_i,
    input logic                  itlb_refill_i,
    input logic                  dtlb_refill_i
);

    // Request held until memory takes it
    mem_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i && $stable(mem_req_addr_i))
        else $error("memory request dropped or changed before acceptance");

    ifetch_resp_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ifetch_resp_valid_i |-> !ifetch_ready_i)
        else $error("instruction response while ready");

    dmem_resp_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dmem_resp_valid_i |-> !dmem_ready_i)
        else $error("data response while ready");

    refill_one_side: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(itlb_refill_i && dtlb_refill_i))
        else $error("refill strobe on both buses");

endmodule

bind mmu_top mmu_asserts asserts_inst (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .mem_req_valid_i    (mem_req_valid_o),
    .mem_req_addr_i     (mem_req_addr_o),
    .mem_req_ready_i    (mem_req_ready_i),
    .ifetch_ready_i     (ifetch_ready_o),
    .ifetch_resp_valid_i(ifetch_resp_valid_o),
    .dmem_ready_i       (dmem_ready_o),
    .dmem_resp_valid_i  (dmem_resp_valid_o),
    .itlb_refill_i      (itlb_bus.refill_valid),
    .dtlb_refill_i      (dtlb_bus.refill_valid)
);

`default_nettype wire

//--- mmu_checker.sv
// Response checker for both TLB sides with a reference translation function
`timescale 1ns/1ps
`default_nettype none

module mmu_checker
    import mmu_pkg::*;
#(
    parameter logic [PpnWidth-1:0] PpnPattern = '0
)(
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                vm_enable_i,
    input  logic                ifetch_req_i,
    input  logic [VpnWidth-1:0] ifetch_vpn_i,
    input  logic                ifetch_ready_i,
    input  logic                ifetch_resp_valid_i,
    input  logic                ifetch_xcpt_i,
    input  logic [PpnWidth-1:0] ifetch_ppn_i,
    input  logic                dmem_req_i,
    input  logic                dmem_store_i,
    input  logic [VpnWidth-1:0] dmem_vpn_i,
    input  logic                dmem_ready_i,
    input  logic                dmem_resp_valid_i,
    input  logic                dmem_xcpt_i,
    input  logic [PpnWidth-1:0] dmem_ppn_i,
    output int                  err_cnt_o,
    output int                  chk_cnt_o
);

    // Expected {xcpt, ppn}, one queue per side
    logic [PpnWidth:0] ifetch_exp_q[$];
    logic [PpnWidth:0] dmem_exp_q[$];
    int                err_cnt;
    int                chk_cnt;

    assign err_cnt_o = err_cnt;
    assign chk_cnt_o = chk_cnt;

    // Translation by the page table rules, PTE fields taken from the VPN
    function automatic logic [PpnWidth:0] expect_xlate(input logic [VpnWidth-1:0] vpn,
                                                       input access_t acc, input logic vm);
        logic v;
        logic perm;
        if (!vm) begin
            return {1'b0, PpnWidth'(vpn)};
        end
        v = (vpn[3:0] != 4'hf);
        case (acc)
            ACC_FETCH: perm = vpn[6];
            ACC_LOAD:  perm = vpn[4];
            default:   perm = vpn[5];
        endcase
        return {!(v && perm), PpnWidth'(vpn) ^ PpnPattern};
    endfunction

    task automatic compare(input string side, input logic [PpnWidth:0] exp,
                           input logic xcpt, input logic [PpnWidth-1:0] ppn);
        chk_cnt++;
        if (ppn !== exp[PpnWidth-1:0]) begin
            $display("Fail %s_ppn_o expected 0x%h got 0x%h", side, exp[PpnWidth-1:0], ppn);
            err_cnt++;
        end
        if (xcpt !== exp[PpnWidth]) begin
            $display("Fail %s_xcpt_o expected 0x%h got 0x%h", side, exp[PpnWidth], xcpt);
            err_cnt++;
        end
    endtask

    // Ready is low exactly while a request of that side is outstanding
    task automatic check_ready(input string side, input int pending, input logic ready);
        if (ready !== (pending == 0)) begin
            $display("Fail %s_ready_o expected 0x%h got 0x%h", side, pending == 0, ready);
            err_cnt++;
        end
    endtask

    initial begin
        err_cnt = 0;
        chk_cnt = 0;
    end

    always @(posedge clk_i) begin
        if (rst_n_i) begin
            check_ready("ifetch", ifetch_exp_q.size(), ifetch_ready_i);
            check_ready("dmem", dmem_exp_q.size(), dmem_ready_i);
            if (ifetch_ready_i && ifetch_req_i) begin
                ifetch_exp_q.push_back(expect_xlate(ifetch_vpn_i, ACC_FETCH, vm_enable_i));
            end
            if (dmem_ready_i && dmem_req_i) begin
                dmem_exp_q.push_back(expect_xlate(dmem_vpn_i,
                    dmem_store_i ? ACC_STORE : ACC_LOAD, vm_enable_i));
            end
            if (ifetch_resp_valid_i) begin
                if (ifetch_exp_q.size() == 0) begin
                    $display("Instruction side answered with no request outstanding");
                    err_cnt++;
                end else begin
                    compare("ifetch", ifetch_exp_q.pop_front(), ifetch_xcpt_i, ifetch_ppn_i);
                end
            end
            if (dmem_resp_valid_i) begin
                if (dmem_exp_q.size() == 0) begin
                    $display("Data side answered with no request outstanding");
                    err_cnt++;
                end else begin
                    compare("dmem", dmem_exp_q.pop_front(), dmem_xcpt_i, dmem_ppn_i);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- mmu_top.sv
// MMU top level with instruction TLB, data TLB and the shared page table walker
`timescale 1ns/1ps
`default_nettype none

module mmu_top
    import mmu_pkg::*;
#(
    parameter int unsigned TlbEntries = 8
)(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  vm_enable_i,
    input  logic                  flush_i,
    input  logic [PpnWidth-1:0]   ptbr_i,

    // ------------------------------------------------------------------------
    // Instruction fetch side
    // ------------------------------------------------------------------------
    input  logic                  ifetch_req_i,
    input  logic [VpnWidth-1:0]   ifetch_vpn_i,
    output logic                  ifetch_ready_o,
    output logic                  ifetch_resp_valid_o,
    output logic                  ifetch_xcpt_o,
    output logic [PpnWidth-1:0]   ifetch_ppn_o,

    // ------------------------------------------------------------------------
    // Data memory side
    // ------------------------------------------------------------------------
    input  logic                  dmem_req_i,
    input  logic                  dmem_store_i,
    input  logic [VpnWidth-1:0]   dmem_vpn_i,
    output logic                  dmem_ready_o,
    output logic                  dmem_resp_valid_o,
    output logic                  dmem_xcpt_o,
    output logic [PpnWidth-1:0]   dmem_ppn_o,

    // ------------------------------------------------------------------------
    // Page table memory port
    // ------------------------------------------------------------------------
    output logic                  mem_req_valid_o,
    output logic [PAddrWidth-1:0] mem_req_addr_o,
    input  logic                  mem_req_ready_i,
    input  logic                  mem_resp_valid_i,
    input  logic [PteWidth-1:0]   mem_resp_data_i
);

    tlb_ptw_if itlb_bus ();
    tlb_ptw_if dtlb_bus ();

    // Fetch TLB never stores
    tlb #(
        .TLB_ENTRIES(TlbEntries),
        .IsFetch    (1'b1)
    ) itlb (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .vm_enable_i (vm_enable_i),
        .flush_i     (flush_i),
        .req_i       (ifetch_req_i),
        .store_i     (1'b0),
        .vpn_i       (ifetch_vpn_i),
        .ready_o     (ifetch_ready_o),
        .resp_valid_o(ifetch_resp_valid_o),
        .xcpt_o      (ifetch_xcpt_o),
        .ppn_o       (ifetch_ppn_o),
        .ptw         (itlb_bus.tlb)
    );

    tlb #(
        .TLB_ENTRIES(TlbEntries)
    ) dtlb (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .vm_enable_i (vm_enable_i),
        .flush_i     (flush_i),
        .req_i       (dmem_req_i),
        .store_i     (dmem_store_i),
        .vpn_i       (dmem_vpn_i),
        .ready_o     (dmem_ready_o),
        .resp_valid_o(dmem_resp_valid_o),
        .xcpt_o      (dmem_xcpt_o),
        .ppn_o       (dmem_ppn_o),
        .ptw         (dtlb_bus.tlb)
    );

    ptw ptw_inst (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .ptbr_i          (ptbr_i),
        .itlb            (itlb_bus.ptw),
        .dtlb            (dtlb_bus.ptw),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_resp_valid_i(mem_resp_valid_i),
        .mem_resp_data_i (mem_resp_data_i)
    );

endmodule

`default_nettype wire

//--- ptw.sv
// Page table walker serving the instruction and data TLBs from one memory port
`timescale 1ns/1ps
`default_nettype none

module ptw
    import mmu_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic [PpnWidth-1:0]   ptbr_i,
    tlb_ptw_if.ptw                itlb,
    tlb_ptw_if.ptw                dtlb,
    output logic                  mem_req_valid_o,
    output logic [PAddrWidth-1:0] mem_req_addr_o,
    input  logic                  mem_req_ready_i,
    input  logic                  mem_resp_valid_i,
    input  logic [PteWidth-1:0]   mem_resp_data_i
);

    ptw_state_t state_q;

    // Side being served, set when the walk starts
    logic serve_dtlb_q;

    logic [PAddrWidth-1:0] addr_q;
    logic [PteWidth-1:0]   pte_q;

    logic                  start;
    logic [VpnWidth-1:0]   sel_vpn;
    logic [PAddrWidth-1:0] pte_addr;

    // ------------------------------------------------------------------------
    // Arbitration and entry address
    // ------------------------------------------------------------------------
    // Data side has fixed priority
    assign start   = (state_q == PTW_IDLE) && (itlb.miss_valid || dtlb.miss_valid);
    assign sel_vpn = dtlb.miss_valid ? dtlb.miss_vpn : itlb.miss_vpn;

    // base * 4096 + vpn * 8
    assign pte_addr = {ptbr_i, {PageOffsetBits{1'b0}}}
                    + (PAddrWidth'(sel_vpn) << PteSizeLog2);

    // ------------------------------------------------------------------------
    // Walk FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= PTW_IDLE;
            serve_dtlb_q <= 1'b0;
        end else begin
            case (state_q)
                PTW_IDLE: begin
                    if (start) begin
                        state_q      <= PTW_MEM_REQ;
                        serve_dtlb_q <= dtlb.miss_valid;
                    end
                end
                // Held here while memory back-pressures
                PTW_MEM_REQ: begin
                    if (mem_req_ready_i) begin
                        state_q <= PTW_MEM_WAIT;
                    end
                end
                PTW_MEM_WAIT: begin
                    if (mem_resp_valid_i) begin
                        state_q <= PTW_REFILL;
                    end
                end
                PTW_REFILL: begin
                    state_q <= PTW_IDLE;
                end
                default: state_q <= PTW_IDLE;
            endcase
        end
    end

    // Address latched with the VPN so it stays stable during back-pressure
    always_ff @(posedge clk_i) begin
        if (start) begin
            addr_q <= pte_addr;
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == PTW_MEM_WAIT) && mem_resp_valid_i) begin
            pte_q <= mem_resp_data_i;
        end
    end

    // ------------------------------------------------------------------------
    // Memory request and refill outputs
    // ------------------------------------------------------------------------
    assign mem_req_valid_o = (state_q == PTW_MEM_REQ);
    assign mem_req_addr_o  = addr_q;

    // Refill strobe goes only to the side that missed
    assign itlb.refill_valid = (state_q == PTW_REFILL) && !serve_dtlb_q;
    assign dtlb.refill_valid = (state_q == PTW_REFILL) && serve_dtlb_q;
    assign itlb.refill_pte   = pte_q;
    assign dtlb.refill_pte   = pte_q;

endmodule

`default_nettype wire

//--- tlb.sv
// Direct-mapped TLB with lookup, permission check, passthrough and refill
`timescale 1ns/1ps
`default_nettype none

module tlb
    import mmu_pkg::*;
#(
    parameter int unsigned TLB_ENTRIES = 8,
    parameter bit          IsFetch     = 1'b0
)(
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                vm_enable_i,
    input  logic                flush_i,
    input  logic                req_i,
    input  logic                store_i,
    input  logic [VpnWidth-1:0] vpn_i,
    output logic                ready_o,
    output logic                resp_valid_o,
    output logic                xcpt_o,
    output logic [PpnWidth-1:0] ppn_o,
    tlb_ptw_if.tlb              ptw
);

    localparam int unsigned IdxBits = $clog2(TLB_ENTRIES);
    localparam int unsigned TagBits = VpnWidth - IdxBits;

    typedef enum logic [1:0] {
        TLB_READY  = 2'd0,
        TLB_LOOKUP = 2'd1,
        TLB_MISS   = 2'd2
    } tlb_state_t;

    tlb_state_t state_q;

    // Request held from acceptance until the response
    logic [VpnWidth-1:0] vpn_q;
    access_t             acc_q;

    // Entry array, indexed by the low VPN bits
    logic [TLB_ENTRIES-1:0] entry_valid_q;
    logic [TLB_ENTRIES-1:0] pte_v_q;
    logic [TLB_ENTRIES-1:0] perm_r_q;
    logic [TLB_ENTRIES-1:0] perm_w_q;
    logic [TLB_ENTRIES-1:0] perm_x_q;
    logic [TagBits-1:0]     tag_q [TLB_ENTRIES];
    logic [PpnWidth-1:0]    ppn_q [TLB_ENTRIES];

    logic [IdxBits-1:0] idx;
    logic [TagBits-1:0] tag;
    logic               hit;
    logic               perm_ok;
    logic               refill_we;

    assign idx       = vpn_q[IdxBits-1:0];
    assign tag       = vpn_q[VpnWidth-1:IdxBits];
    assign hit       = entry_valid_q[idx] && (tag_q[idx] == tag);
    assign refill_we = (state_q == TLB_MISS) && ptw.refill_valid;

    // Permission bit required by the access type
    always_comb begin
        case (acc_q)
            ACC_FETCH: perm_ok = perm_x_q[idx];
            ACC_LOAD:  perm_ok = perm_r_q[idx];
            ACC_STORE: perm_ok = perm_w_q[idx];
            default:   perm_ok = 1'b0;
        endcase
    end

    assign ready_o      = (state_q == TLB_READY);
    assign resp_valid_o = (state_q == TLB_LOOKUP) && (!vm_enable_i || hit);
    // Translation off: VPN passes through zero-extended, never faults
    assign ppn_o        = vm_enable_i ? ppn_q[idx] : PpnWidth'(vpn_q);
    assign xcpt_o       = vm_enable_i && !(pte_v_q[idx] && perm_ok);

    assign ptw.miss_valid = (state_q == TLB_MISS);
    assign ptw.miss_vpn   = vpn_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= TLB_READY;
        end else begin
            case (state_q)
                TLB_READY: begin
                    if (req_i) begin
                        state_q <= TLB_LOOKUP;
                    end
                end
                TLB_LOOKUP: begin
                    state_q <= (vm_enable_i && !hit) ? TLB_MISS : TLB_READY;
                end
                // Refilled entry is looked up again next cycle
                TLB_MISS: begin
                    if (ptw.refill_valid) begin
                        state_q <= TLB_LOOKUP;
                    end
                end
                default: state_q <= TLB_READY;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (ready_o && req_i) begin
            vpn_q <= vpn_i;
            if (IsFetch) begin
                acc_q <= ACC_FETCH;
            end else if (store_i) begin
                acc_q <= ACC_STORE;
            end else begin
                acc_q <= ACC_LOAD;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            entry_valid_q <= '0;
        end else if (flush_i) begin
            entry_valid_q <= '0;
        end else if (refill_we) begin
            entry_valid_q[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (refill_we) begin
            tag_q[idx]    <= tag;
            ppn_q[idx]    <= ptw.refill_pte[PTE_PPN_LSB +: PpnWidth];
            pte_v_q[idx]  <= ptw.refill_pte[PTE_V_BIT];
            perm_r_q[idx] <= ptw.refill_pte[PTE_R_BIT];
            perm_w_q[idx] <= ptw.refill_pte[PTE_W_BIT];
            perm_x_q[idx] <= ptw.refill_pte[PTE_X_BIT];
        end
    end

endmodule

`default_nettype wire

//--- tlb_ptw_if.sv
// Miss and refill bus between one TLB and the page table walker
`timescale 1ns/1ps
`default_nettype none

interface tlb_ptw_if
    import mmu_pkg::*;
();

    // Level held by the TLB while it waits for a walk
    logic                miss_valid;
    logic [VpnWidth-1:0] miss_vpn;

    // One-cycle strobe from the walker, entry alongside
    logic                refill_valid;
    logic [PteWidth-1:0] refill_pte;

    modport tlb (
        output miss_valid,
        output miss_vpn,
        input  refill_valid,
        input  refill_pte
    );

    modport ptw (
        input  miss_valid,
        input  miss_vpn,
        output refill_valid,
        output refill_pte
    );

endinterface

`default_nettype wire

//--- mmu_pkg.sv
// Widths, page table constants, access type and walker state enums of the MMU
`default_nettype none

package mmu_pkg;

    // ------------------------------------------------------------------------
    // Address and entry widths
    // ------------------------------------------------------------------------
    localparam int unsigned VpnWidth   = 27;
    localparam int unsigned PpnWidth   = 44;
    localparam int unsigned PAddrWidth = 56;
    localparam int unsigned PteWidth   = 64;

    // ------------------------------------------------------------------------
    // Single-level page table
    // ------------------------------------------------------------------------
    // Entry address is base * 4096 + vpn * 8
    localparam int unsigned PageOffsetBits = 12;
    localparam int unsigned PteSizeLog2    = 3;

    // Entry field positions
    localparam int unsigned PTE_V_BIT   = 0;
    localparam int unsigned PTE_R_BIT   = 1;
    localparam int unsigned PTE_W_BIT   = 2;
    localparam int unsigned PTE_X_BIT   = 3;
    localparam int unsigned PTE_PPN_LSB = 10;

    // Kind of access a translation request makes
    typedef enum logic [1:0] {
        ACC_FETCH = 2'd0,
        ACC_LOAD  = 2'd1,
        ACC_STORE = 2'd2
    } access_t;

    // Walker FSM
    typedef enum logic [1:0] {
        PTW_IDLE     = 2'd0,
        PTW_MEM_REQ  = 2'd1,
        PTW_MEM_WAIT = 2'd2,
        PTW_REFILL   = 2'd3
    } ptw_state_t;

endpackage

`default_nettype wire
